//--- sources.f
source/mips_isa_pkg.sv
source/pipe_pkg.sv
source/reg_file.sv
source/decoder.sv
source/hazard_unit.sv
source/alu.sv
source/mips_core.sv
tests/tb_clock.sv
tests/mips_core_asserts.sv
tests/tb_mips_core.sv

//--- tests/core_tests.dat
# T name | I inst | D byte_addr data | W pc reg value | S byte_addr data | E runs the test
# all numbers hex; W and S records are expected in program order
T alu_forwarding
I 24010005
I 24220003
I 00221821
I 00612023
I 3c058000
I 00053103
I 00c1382a
I 388800ff
W bfc00000 01 00000005
W bfc00004 02 00000008
W bfc00008 03 0000000d
W bfc0000c 04 00000008
W bfc00010 05 80000000
W bfc00014 06 f8000000
W bfc00018 07 00000001
W bfc0001c 08 000000f7
E
T load_store
D 00000100 cafef00d
I 24010100
I 8c220000
I 24430001
I ac230004
I 8c240004
I 00822823
W bfc00000 01 00000100
W bfc00004 02 cafef00d
W bfc00008 03 cafef00e
S 00000104 cafef00e
W bfc00010 04 cafef00e
W bfc00014 05 00000001
E
T branch_jump_r0
I 24010001
I 10200004
I 24020002
I 14200002
I 24030003
I 24040044
I 0ff0000a
I 24050005
I 24060006
I 24060007
I 27ff0014
I 03e00008
I 24070009
I 0bf00010
I 24080008
I 24090001
I 24000005
I 240a0077
W bfc00000 01 00000001
W bfc00008 02 00000002
W bfc00010 03 00000003
W bfc00018 1f bfc00020
W bfc0001c 05 00000005
W bfc00028 1f bfc00034
W bfc00030 07 00000009
W bfc00038 08 00000008
W bfc00044 0a 00000077
E

//--- tests/tb_mips_core.sv
`timescale 1ns/1ps
// runs the programs in tests/core_tests.dat, run from the project root
// both SRAMs are 1024 words, instruction words start at reset_pc
module tb_mips_core;

    localparam int mem_words      = 1024;
    localparam int reset_cycles   = 16;
    localparam int cycles_per_ins = 20;

    logic                          clk;
    logic                          resetn;
    pipe_pkg::sram_req_t           inst_req;
    pipe_pkg::sram_req_t           data_req;
    logic [mips_isa_pkg::xlen-1:0] inst_rdata;
    logic [mips_isa_pkg::xlen-1:0] data_rdata;
    pipe_pkg::wb_trace_t           wb_trace;

    logic [31:0] imem [0:mem_words-1];
    logic [31:0] dmem [0:mem_words-1];
    logic [31:0] inst_addr_q;          // request captured at the edge
    pipe_pkg::sram_req_t data_req_q;

    string       test_name;
    logic [31:0] prog_q[$];
    logic [31:0] dinit_addr_q[$];
    logic [31:0] dinit_data_q[$];
    logic [31:0] w_pc_q[$];
    logic [31:0] w_reg_q[$];
    logic [31:0] w_val_q[$];
    logic [31:0] s_addr_q[$];
    logic [31:0] s_data_q[$];
    int          w_idx;
    int          s_idx;
    bit          running;
    int          watchdog_cycles;

    tb_clock u_clock (.clk(clk));

    mips_core UUT (
        .clk(clk), .resetn(resetn),
        .inst_req(inst_req), .inst_rdata(inst_rdata),
        .data_req(data_req), .data_rdata(data_rdata),
        .wb_trace(wb_trace)
    );

    task automatic report_failure(input string why);
        $display("%s", why);
        $display("TB FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("CHECK FAILED test=%s %s expected=%h actual=%h",
                     test_name, what, expected, actual);
            report_failure("value mismatch");
        end
    endtask

    // ------------------------------------------------------------
    // synchronous-read SRAMs, data out 1 ns after the edge
    always @(posedge clk) begin
        inst_addr_q = inst_req.addr - mips_isa_pkg::reset_pc;
        data_req_q = data_req;
        if (data_req_q.en && data_req_q.wen == 4'hf) begin
            dmem[data_req_q.addr[11:2]] = data_req_q.wdata;
        end
        #1;
        inst_rdata <= imem[inst_addr_q[11:2]];
        if (data_req_q.en) begin
            data_rdata <= dmem[data_req_q.addr[11:2]];   // holds while idle
        end
    end

    // ------------------------------------------------------------
    // trace and store checking against the expected streams
    always @(posedge clk) begin
        if (UUT.u_asserts.fail_count != 0) begin
            report_failure("a bound assertion on the core outputs failed");
        end
        if (running && wb_trace.rf_wen != 4'h0) begin
            if (w_idx >= w_pc_q.size()) begin
                report_failure($sformatf("unexpected writeback in test %s", test_name));
            end
            check_value("wb pc", w_pc_q[w_idx], wb_trace.pc);
            check_value("wb reg", w_reg_q[w_idx], 32'(wb_trace.rf_wnum));
            check_value("wb data", w_val_q[w_idx], wb_trace.rf_wdata);
            w_idx++;
        end
        if (running && data_req.en && data_req.wen != 4'h0) begin
            if (s_idx >= s_addr_q.size()) begin
                report_failure($sformatf("unexpected store in test %s", test_name));
            end
            check_value("store wen", 32'hf, 32'(data_req.wen));
            check_value("store addr", s_addr_q[s_idx], data_req.addr);
            check_value("store data", s_data_q[s_idx], data_req.wdata);
            s_idx++;
        end
    end

    task automatic run_test();
        @(posedge clk);
        #1;
        running = 1'b0;
        resetn = 1'b0;
        for (int i = 0; i < mem_words; i++) begin
            imem[i] = 32'h0000_0000;                 // nop
            dmem[i] = 32'h5a5a_0000 ^ (i << 2);      // pattern follows address
        end
        foreach (prog_q[i]) imem[i] = prog_q[i];
        foreach (dinit_addr_q[i]) dmem[dinit_addr_q[i][11:2]] = dinit_data_q[i];
        w_idx = 0;
        s_idx = 0;
        repeat (reset_cycles) @(posedge clk);
        #1;
        resetn = 1'b1;
        running = 1'b1;
        @(posedge clk);
        check_value("first fetch", mips_isa_pkg::reset_pc, inst_req.addr);
        // counters settle at the edge, look at them just after it
        while (w_idx < w_pc_q.size() || s_idx < s_addr_q.size()) begin
            @(posedge clk);
            #1;
        end
        running = 1'b0;
    endtask

    // ------------------------------------------------------------
    // watchdog, sized from the program lengths
    initial begin
        wait (watchdog_cycles > 0);
        repeat (watchdog_cycles) @(posedge clk);
        report_failure("watchdog expired before all tests completed");
    end

    initial begin
        int          fd;
        int          n_ins;
        int          n_tests;
        string       line;
        string       tag;
        logic [31:0] a, b, c;

        resetn = 1'b0;
        inst_rdata = '0;
        data_rdata = '0;
        running = 1'b0;
        watchdog_cycles = 0;
        w_idx = 0;
        s_idx = 0;
        n_ins = 0;
        n_tests = 0;
        test_name = "none";

        // first pass just counts work for the watchdog
        fd = $fopen("tests/core_tests.dat", "r");
        if (fd == 0) begin
            report_failure("cannot open tests/core_tests.dat");
        end
        while ($fgets(line, fd) > 0) begin
            if ($sscanf(line, "%s", tag) == 1) begin
                if (tag == "I") n_ins++;
                if (tag == "T") n_tests++;
            end
        end
        $fclose(fd);
        watchdog_cycles = cycles_per_ins * (n_ins + n_tests);

        fd = $fopen("tests/core_tests.dat", "r");
        while ($fgets(line, fd) > 0) begin
            if ($sscanf(line, "%s", tag) != 1 || tag.substr(0, 0) == "#") continue;
            case (tag)
                "T": begin
                    void'($sscanf(line, "%s %s", tag, test_name));
                    prog_q.delete();
                    dinit_addr_q.delete();
                    dinit_data_q.delete();
                    w_pc_q.delete();
                    w_reg_q.delete();
                    w_val_q.delete();
                    s_addr_q.delete();
                    s_data_q.delete();
                end
                "I": begin
                    void'($sscanf(line, "%s %h", tag, a));
                    prog_q.push_back(a);
                end
                "D": begin
                    void'($sscanf(line, "%s %h %h", tag, a, b));
                    dinit_addr_q.push_back(a);
                    dinit_data_q.push_back(b);
                end
                "W": begin
                    void'($sscanf(line, "%s %h %h %h", tag, a, b, c));
                    w_pc_q.push_back(a);
                    w_reg_q.push_back(b);
                    w_val_q.push_back(c);
                end
                "S": begin
                    void'($sscanf(line, "%s %h %h", tag, a, b));
                    s_addr_q.push_back(a);
                    s_data_q.push_back(b);
                end
                "E": run_test();
                default: report_failure($sformatf("bad line in test file: %s", line));
            endcase
        end
        $fclose(fd);

        if (UUT.u_asserts.fail_count != 0) begin
            report_failure("a bound assertion on the core outputs failed");
        end else begin
            $display("TB PASSED");
            $finish;
        end
    end

endmodule

//--- tests/mips_core_asserts.sv
`timescale 1ns/1ps
// protocol checks on the core's outputs, bound into mips_core
// fail_count is read by the testbench to end the run
module mips_core_asserts (
    input logic                clk,
    input logic                resetn,
    input pipe_pkg::sram_req_t inst_req,
    input pipe_pkg::sram_req_t data_req,
    input pipe_pkg::wb_trace_t wb_trace
);
    int fail_count = 0;

    // r0 writes never show up on the trace
    wnum_nonzero: assert property (@(posedge clk) disable iff (!resetn)
        (wb_trace.rf_wen != 4'h0) |-> (wb_trace.rf_wnum != '0))
        else begin
            fail_count++;
            $error("trace write to register 0");
        end

    wen_all_or_none: assert property (@(posedge clk) disable iff (!resetn)
        wb_trace.rf_wen inside {4'h0, 4'hf})
        else begin
            fail_count++;
            $error("rf_wen is partial");
        end

    dwen_needs_en: assert property (@(posedge clk) disable iff (!resetn)
        (data_req.wen != 4'h0) |-> data_req.en)
        else begin
            fail_count++;
            $error("data write strobe without enable");
        end

    // fetch port is a plain read every cycle
    inst_read_only: assert property (@(posedge clk) disable iff (!resetn)
        inst_req.en && inst_req.wen == 4'h0 && inst_req.wdata == '0)
        else begin
            fail_count++;
            $error("instruction port is not a plain enabled read");
        end

endmodule

bind mips_core mips_core_asserts u_asserts (.*);

//--- tests/tb_clock.sv
`timescale 1ns/1ps
// free-running testbench clock, 4 ns period, starts low
module tb_clock (
    output logic clk
);
    localparam time half_period = 2ns;

    initial begin
        clk = 1'b0;
    end

    always #(half_period) clk = ~clk;

endmodule

//--- source/mips_core.sv
`timescale 1ns/1ps
// 5-stage in-order MIPS32 core, branches resolve in decode, delay slot always runs
// both SRAMs are synchronous read; no exceptions and no external back-pressure
module mips_core (
    input  logic                          clk,
    input  logic                          resetn,
    output pipe_pkg::sram_req_t           inst_req,
    input  logic [mips_isa_pkg::xlen-1:0] inst_rdata,
    output pipe_pkg::sram_req_t           data_req,
    input  logic [mips_isa_pkg::xlen-1:0] data_rdata,
    output pipe_pkg::wb_trace_t           wb_trace
);
    logic [mips_isa_pkg::xlen-1:0] pc, fetch_pc;   // pc: address whose word is on inst_rdata
    logic                          fetch_valid;
    logic                          id_valid;
    logic [mips_isa_pkg::xlen-1:0] id_pc, id_inst;
    logic [mips_isa_pkg::reg_addr_w-1:0] id_rs, id_rt;
    pipe_pkg::ctrl_t               dec_ctrl, id_ctrl;
    logic [mips_isa_pkg::xlen-1:0] rf_rdata1, rf_rdata2, rs_val, rt_val;
    logic [mips_isa_pkg::xlen-1:0] simm, uimm, op_a, op_b;
    logic [mips_isa_pkg::xlen-1:0] ds_pc, br_target, redirect_pc;
    logic                          branch_hit, taken;
    logic [1:0]                    fwd_a, fwd_b;
    logic                          stall;
    pipe_pkg::ex_stage_t           ex_stage;
    pipe_pkg::mem_stage_t          mem_stage;
    pipe_pkg::wb_stage_t           wb_stage;
    logic [mips_isa_pkg::xlen-1:0] ex_result, mem_result;
    logic                          wb_we;

    function automatic logic [mips_isa_pkg::xlen-1:0] fwd_value(
        input logic [1:0]                    sel,
        input logic [mips_isa_pkg::xlen-1:0] rf_val
    );
        case (sel)
            pipe_pkg::fwd_ex:  return ex_result;
            pipe_pkg::fwd_mem: return mem_result;
            pipe_pkg::fwd_wb:  return wb_stage.result;
            default:           return rf_val;
        endcase
    endfunction

    // ------------------------------------------------------------
    // fetch
    assign fetch_pc = taken ? redirect_pc : (stall ? pc : pc + 32'd4);
    assign inst_req = '{en: 1'b1, wen: 4'b0000, addr: fetch_pc, wdata: '0};

    always_ff @(posedge clk) begin
        if (!resetn) begin
            pc <= mips_isa_pkg::reset_pc - 32'd4;   // first fetch lands on reset_pc
            fetch_valid <= 1'b0;
            id_valid <= 1'b0;
        end else begin
            pc <= fetch_pc;
            fetch_valid <= 1'b1;
            if (!stall) begin
                id_valid <= fetch_valid;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin      // decode register holds during a stall
            id_pc <= pc;
            id_inst <= inst_rdata;
        end
    end

    // ------------------------------------------------------------
    // decode, operand forwarding, branch resolve
    assign id_rs = id_inst[mips_isa_pkg::rs_lsb +: mips_isa_pkg::reg_addr_w];
    assign id_rt = id_inst[mips_isa_pkg::rt_lsb +: mips_isa_pkg::reg_addr_w];

    decoder u_decoder (.inst(id_inst), .ctrl(dec_ctrl), .illegal());
    assign id_ctrl = id_valid ? dec_ctrl : '0;

    reg_file u_reg_file (
        .clk(clk), .resetn(resetn),
        .raddr1(id_rs), .raddr2(id_rt), .rdata1(rf_rdata1), .rdata2(rf_rdata2),
        .wen(wb_we), .waddr(wb_stage.dest), .wdata(wb_stage.result)
    );

    hazard_unit u_hazard (
        .id_rs(id_rs), .id_rt(id_rt), .id_ctrl(id_ctrl),
        .ex_stage(ex_stage), .mem_stage(mem_stage), .wb_stage(wb_stage),
        .fwd_a(fwd_a), .fwd_b(fwd_b), .stall(stall)
    );

    // fwd_value reads the later-stage results directly
    always_comb begin
        rs_val = fwd_value(fwd_a, rf_rdata1);
        rt_val = fwd_value(fwd_b, rf_rdata2);
    end
    assign simm = {{(mips_isa_pkg::xlen - mips_isa_pkg::imm_w){id_inst[mips_isa_pkg::imm_w-1]}},
                   id_inst[mips_isa_pkg::imm_w-1:0]};
    assign uimm = {{(mips_isa_pkg::xlen - mips_isa_pkg::imm_w){1'b0}},
                   id_inst[mips_isa_pkg::imm_w-1:0]};

    always_comb begin
        if (id_ctrl.a_src == pipe_pkg::a_shamt) begin
            op_a = {{(mips_isa_pkg::xlen - 5){1'b0}}, id_inst[mips_isa_pkg::sa_lsb +: 5]};
        end else begin
            op_a = id_ctrl.reads_rs ? rs_val : '0;   // lui, jal see zero
        end
        case (id_ctrl.b_src)
            pipe_pkg::b_simm: op_b = simm;
            pipe_pkg::b_uimm: op_b = uimm;
            pipe_pkg::b_pc8:  op_b = id_pc + 32'd8;   // jal link
            default:          op_b = rt_val;
        endcase
    end

    assign ds_pc = id_pc + 32'd4;                     // delay slot
    assign br_target = ds_pc + {simm[mips_isa_pkg::xlen-3:0], 2'b00};

    always_comb begin
        branch_hit = 1'b0;
        redirect_pc = {ds_pc[31:28], id_inst[mips_isa_pkg::index_w-1:0], 2'b00};  // j, jal
        case (id_ctrl.branch)
            pipe_pkg::br_beq: begin
                branch_hit = (rs_val == rt_val);
                redirect_pc = br_target;
            end
            pipe_pkg::br_bne: begin
                branch_hit = (rs_val != rt_val);
                redirect_pc = br_target;
            end
            pipe_pkg::br_jr: begin
                branch_hit = 1'b1;
                redirect_pc = rs_val;
            end
            pipe_pkg::br_j, pipe_pkg::br_jal: branch_hit = 1'b1;
            default: branch_hit = 1'b0;
        endcase
    end
    assign taken = branch_hit && !stall;   // operands must be final

    // ------------------------------------------------------------
    // execute, memory, writeback
    always_ff @(posedge clk) begin
        if (!resetn || stall) begin
            ex_stage <= '0;                  // bubble
        end else begin
            ex_stage <= '{pc: id_pc, ctrl: id_ctrl, op_a: op_a, op_b: op_b,
                          store_data: rt_val, mem_addr: rs_val + simm};
        end
    end

    alu u_alu (.op(ex_stage.ctrl.alu_op), .a(ex_stage.op_a), .b(ex_stage.op_b),
               .result(ex_result));

    assign data_req = '{en: ex_stage.ctrl.mem_read | ex_stage.ctrl.mem_write,
                        wen: {4{ex_stage.ctrl.mem_write}},
                        addr: ex_stage.mem_addr, wdata: ex_stage.store_data};

    assign mem_result = mem_stage.mem_read ? data_rdata : mem_stage.result;
    assign wb_we = wb_stage.reg_write && wb_stage.dest != '0;  // r0 writes dropped

    always_ff @(posedge clk) begin
        if (!resetn) begin
            mem_stage <= '0;
            wb_stage <= '0;
        end else begin
            mem_stage <= '{pc: ex_stage.pc, dest: ex_stage.ctrl.dest,
                           reg_write: ex_stage.ctrl.reg_write,
                           mem_read: ex_stage.ctrl.mem_read, result: ex_result};
            wb_stage <= '{pc: mem_stage.pc, dest: mem_stage.dest,
                          reg_write: mem_stage.reg_write,
                          mem_read: mem_stage.mem_read, result: mem_result};
        end
    end

    assign wb_trace = '{pc: wb_stage.pc, rf_wen: {4{wb_we}}, rf_wnum: wb_stage.dest,
                        rf_wdata: wb_stage.result};

endmodule

//--- source/alu.sv
`timescale 1ns/1ps
// integer ALU, no overflow traps; shift amount is a[4:0], value is b
module alu (
    input  pipe_pkg::alu_op_e             op,
    input  logic [mips_isa_pkg::xlen-1:0] a,
    input  logic [mips_isa_pkg::xlen-1:0] b,
    output logic [mips_isa_pkg::xlen-1:0] result
);
    always_comb begin
        case (op)
            pipe_pkg::alu_add:  result = a + b;
            pipe_pkg::alu_sub:  result = a - b;
            pipe_pkg::alu_and:  result = a & b;
            pipe_pkg::alu_or:   result = a | b;
            pipe_pkg::alu_xor:  result = a ^ b;
            pipe_pkg::alu_nor:  result = ~(a | b);
            pipe_pkg::alu_slt: begin
                result = '0;
                result[0] = $signed(a) < $signed(b);
            end
            pipe_pkg::alu_sltu: begin
                result = '0;
                result[0] = a < b;
            end
            pipe_pkg::alu_sll:  result = b << a[4:0];
            pipe_pkg::alu_srl:  result = b >> a[4:0];
            pipe_pkg::alu_sra:  result = $signed(b) >>> a[4:0];
            pipe_pkg::alu_lui:  result = {b[15:0], 16'h0000};   // a unused
            default:            result = '0;
        endcase
    end

endmodule

//--- source/hazard_unit.sv
`timescale 1ns/1ps
// forward selects and decode stall; r0 never matches a producer
// a load in execute, or any execute producer feeding a branch, stalls one cycle
module hazard_unit (
    input  logic [mips_isa_pkg::reg_addr_w-1:0] id_rs,
    input  logic [mips_isa_pkg::reg_addr_w-1:0] id_rt,
    input  pipe_pkg::ctrl_t                     id_ctrl,
    input  pipe_pkg::ex_stage_t                 ex_stage,
    input  pipe_pkg::mem_stage_t                mem_stage,
    input  pipe_pkg::wb_stage_t                 wb_stage,
    output logic [1:0]                          fwd_a,
    output logic [1:0]                          fwd_b,
    output logic                                stall
);
    logic br_use;      // decode compares or jumps on register values
    logic stall_a;
    logic stall_b;

    // returns {stall, select} for one source register
    function automatic logic [2:0] pick(
        input logic [mips_isa_pkg::reg_addr_w-1:0] src,
        input logic                                used
    );
        if (!used || src == '0) begin
            return {1'b0, pipe_pkg::fwd_rf};
        end
        if (ex_stage.ctrl.reg_write && ex_stage.ctrl.dest == src) begin
            if (ex_stage.ctrl.mem_read || br_use) begin
                return {1'b1, pipe_pkg::fwd_rf};      // not ready yet
            end
            return {1'b0, pipe_pkg::fwd_ex};
        end
        if (mem_stage.reg_write && mem_stage.dest == src) begin
            return {1'b0, pipe_pkg::fwd_mem};         // loaded word if lw
        end
        if (wb_stage.reg_write && wb_stage.dest == src) begin
            return {1'b0, pipe_pkg::fwd_wb};
        end
        return {1'b0, pipe_pkg::fwd_rf};
    endfunction

    assign br_use = id_ctrl.branch inside {pipe_pkg::br_beq, pipe_pkg::br_bne,
                                           pipe_pkg::br_jr};

    // pick reads the stage payloads directly
    always_comb begin
        {stall_a, fwd_a} = pick(id_rs, id_ctrl.reads_rs);
        {stall_b, fwd_b} = pick(id_rt, id_ctrl.reads_rt);
    end
    assign stall = stall_a | stall_b;

endmodule

//--- source/decoder.sv
`timescale 1ns/1ps
// decodes the kept subset into a ctrl_t; anything else becomes a no-op
module decoder (
    input  logic [mips_isa_pkg::xlen-1:0] inst,
    output pipe_pkg::ctrl_t               ctrl,
    output logic                          illegal
);
    mips_isa_pkg::opcode_e op;
    mips_isa_pkg::funct_e  fn;

    assign op = mips_isa_pkg::opcode_e'(inst[mips_isa_pkg::xlen-1:mips_isa_pkg::op_lsb]);
    assign fn = mips_isa_pkg::funct_e'(inst[5:0]);

    always_comb begin
        ctrl = '0;            // add, reg sources, no branch
        illegal = 1'b0;
        ctrl.dest = inst[mips_isa_pkg::rt_lsb +: mips_isa_pkg::reg_addr_w];  // i-type default
        ctrl.reads_rs = 1'b1;
        ctrl.reg_write = 1'b1;
        case (op)
            mips_isa_pkg::op_special: begin
                ctrl.dest = inst[mips_isa_pkg::rd_lsb +: mips_isa_pkg::reg_addr_w];
                ctrl.reads_rt = 1'b1;
                case (fn)
                    mips_isa_pkg::fn_addu: ctrl.alu_op = pipe_pkg::alu_add;
                    mips_isa_pkg::fn_subu: ctrl.alu_op = pipe_pkg::alu_sub;
                    mips_isa_pkg::fn_and:  ctrl.alu_op = pipe_pkg::alu_and;
                    mips_isa_pkg::fn_or:   ctrl.alu_op = pipe_pkg::alu_or;
                    mips_isa_pkg::fn_xor:  ctrl.alu_op = pipe_pkg::alu_xor;
                    mips_isa_pkg::fn_nor:  ctrl.alu_op = pipe_pkg::alu_nor;
                    mips_isa_pkg::fn_slt:  ctrl.alu_op = pipe_pkg::alu_slt;
                    mips_isa_pkg::fn_sltu: ctrl.alu_op = pipe_pkg::alu_sltu;
                    mips_isa_pkg::fn_sll:  ctrl.alu_op = pipe_pkg::alu_sll;
                    mips_isa_pkg::fn_srl:  ctrl.alu_op = pipe_pkg::alu_srl;
                    mips_isa_pkg::fn_sra:  ctrl.alu_op = pipe_pkg::alu_sra;
                    mips_isa_pkg::fn_jr: begin
                        ctrl.branch = pipe_pkg::br_jr;
                        ctrl.reads_rt = 1'b0;
                        ctrl.reg_write = 1'b0;
                    end
                    default: illegal = 1'b1;
                endcase
                // shifts take sa in place of rs
                if (fn inside {mips_isa_pkg::fn_sll, mips_isa_pkg::fn_srl,
                               mips_isa_pkg::fn_sra}) begin
                    ctrl.a_src = pipe_pkg::a_shamt;
                    ctrl.reads_rs = 1'b0;
                end
            end
            mips_isa_pkg::op_addiu: ctrl.b_src = pipe_pkg::b_simm;
            mips_isa_pkg::op_slti: begin
                ctrl.alu_op = pipe_pkg::alu_slt;
                ctrl.b_src = pipe_pkg::b_simm;
            end
            mips_isa_pkg::op_andi: begin
                ctrl.alu_op = pipe_pkg::alu_and;
                ctrl.b_src = pipe_pkg::b_uimm;    // logical imms zero-extend
            end
            mips_isa_pkg::op_ori: begin
                ctrl.alu_op = pipe_pkg::alu_or;
                ctrl.b_src = pipe_pkg::b_uimm;
            end
            mips_isa_pkg::op_xori: begin
                ctrl.alu_op = pipe_pkg::alu_xor;
                ctrl.b_src = pipe_pkg::b_uimm;
            end
            mips_isa_pkg::op_lui: begin
                ctrl.alu_op = pipe_pkg::alu_lui;
                ctrl.b_src = pipe_pkg::b_uimm;
                ctrl.reads_rs = 1'b0;
            end
            mips_isa_pkg::op_lw: begin
                ctrl.b_src = pipe_pkg::b_simm;
                ctrl.mem_read = 1'b1;
            end
            mips_isa_pkg::op_sw: begin
                ctrl.b_src = pipe_pkg::b_simm;
                ctrl.mem_write = 1'b1;
                ctrl.reads_rt = 1'b1;             // store data
                ctrl.reg_write = 1'b0;
            end
            mips_isa_pkg::op_beq, mips_isa_pkg::op_bne: begin
                ctrl.branch = (op == mips_isa_pkg::op_beq) ? pipe_pkg::br_beq
                                                          : pipe_pkg::br_bne;
                ctrl.reads_rt = 1'b1;
                ctrl.reg_write = 1'b0;
            end
            mips_isa_pkg::op_j: begin
                ctrl.branch = pipe_pkg::br_j;
                ctrl.reads_rs = 1'b0;
                ctrl.reg_write = 1'b0;
            end
            mips_isa_pkg::op_jal: begin
                ctrl.branch = pipe_pkg::br_jal;
                ctrl.reads_rs = 1'b0;             // a = 0, result = pc+8
                ctrl.b_src = pipe_pkg::b_pc8;
                ctrl.dest = mips_isa_pkg::link_reg;
            end
            default: illegal = 1'b1;
        endcase
        if (illegal) begin
            ctrl = '0;
        end
    end

endmodule

//--- source/reg_file.sv
`timescale 1ns/1ps
// 32x32 register file, r0 hardwired to zero
// reads are combinational and see a same-cycle write
module reg_file (
    input  logic                                clk,
    input  logic                                resetn,
    input  logic [mips_isa_pkg::reg_addr_w-1:0] raddr1,
    input  logic [mips_isa_pkg::reg_addr_w-1:0] raddr2,
    output logic [mips_isa_pkg::xlen-1:0]       rdata1,
    output logic [mips_isa_pkg::xlen-1:0]       rdata2,
    input  logic                                wen,
    input  logic [mips_isa_pkg::reg_addr_w-1:0] waddr,
    input  logic [mips_isa_pkg::xlen-1:0]       wdata
);
    logic [mips_isa_pkg::xlen-1:0] regs [1:31];  // no storage for r0

    always_ff @(posedge clk) begin
        if (!resetn) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // write-through so decode sees the writeback value this cycle
    assign rdata1 = (raddr1 == '0) ? '0 :
                    (wen && waddr == raddr1) ? wdata : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 :
                    (wen && waddr == raddr2) ? wdata : regs[raddr2];

endmodule

//--- source/pipe_pkg.sv
// pipeline control word, stage payloads and port bundles
// an all-zero ctrl_t is a bubble: no write, no memory access, no branch
package pipe_pkg;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_nor,
        alu_slt, alu_sltu, alu_sll, alu_srl, alu_sra, alu_lui
    } alu_op_e;

    typedef enum logic {a_reg, a_shamt} a_src_e;  // a_reg with reads_rs low gives 0
    typedef enum logic [1:0] {b_reg, b_simm, b_uimm, b_pc8} b_src_e;
    typedef enum logic [2:0] {br_none, br_beq, br_bne, br_j, br_jal, br_jr} br_e;

    // forward source selects, youngest producer wins
    localparam logic [1:0] fwd_rf  = 2'd0;
    localparam logic [1:0] fwd_wb  = 2'd1;
    localparam logic [1:0] fwd_mem = 2'd2;
    localparam logic [1:0] fwd_ex  = 2'd3;

    typedef struct packed {
        alu_op_e                               alu_op;
        a_src_e                                a_src;
        b_src_e                                b_src;
        logic                                  reads_rs;
        logic                                  reads_rt;
        logic                                  mem_read;   // lw
        logic                                  mem_write;  // sw
        logic                                  reg_write;
        logic [mips_isa_pkg::reg_addr_w-1:0]   dest;
        br_e                                   branch;
    } ctrl_t;

    typedef struct packed {
        logic [mips_isa_pkg::xlen-1:0] pc;
        ctrl_t                         ctrl;
        logic [mips_isa_pkg::xlen-1:0] op_a;
        logic [mips_isa_pkg::xlen-1:0] op_b;
        logic [mips_isa_pkg::xlen-1:0] store_data;  // forwarded rt
        logic [mips_isa_pkg::xlen-1:0] mem_addr;    // rs + simm, formed in decode
    } ex_stage_t;

    typedef struct packed {
        logic [mips_isa_pkg::xlen-1:0]       pc;
        logic [mips_isa_pkg::reg_addr_w-1:0] dest;
        logic                                reg_write;
        logic                                mem_read;
        logic [mips_isa_pkg::xlen-1:0]       result;
    } mem_stage_t;

    typedef mem_stage_t wb_stage_t;  // same layout, result holds loaded word

    typedef struct packed {
        logic                          en;
        logic [3:0]                    wen;
        logic [mips_isa_pkg::xlen-1:0] addr;
        logic [mips_isa_pkg::xlen-1:0] wdata;
    } sram_req_t;

    typedef struct packed {
        logic [mips_isa_pkg::xlen-1:0]       pc;
        logic [3:0]                          rf_wen;  // all ones or zero
        logic [mips_isa_pkg::reg_addr_w-1:0] rf_wnum;
        logic [mips_isa_pkg::xlen-1:0]       rf_wdata;
    } wb_trace_t;

endpackage

//--- source/mips_isa_pkg.sv
// encodings for the kept MIPS32 integer subset only
// opcodes and functs outside these enums decode as illegal no-ops
package mips_isa_pkg;

    localparam int unsigned xlen       = 32;   // data and address width
    localparam int unsigned reg_addr_w = 5;

    localparam logic [xlen-1:0]       reset_pc = 32'hbfc0_0000;  // boot vector
    localparam logic [reg_addr_w-1:0] link_reg = 5'd31;          // jal destination

    // ------------------------------------------------------------
    // instruction field positions
    localparam int unsigned op_lsb  = 26;
    localparam int unsigned rs_lsb  = 21;
    localparam int unsigned rt_lsb  = 16;
    localparam int unsigned rd_lsb  = 11;
    localparam int unsigned sa_lsb  = 6;    // shift amount
    localparam int unsigned imm_w   = 16;
    localparam int unsigned index_w = 26;   // j/jal index

    // ------------------------------------------------------------
    // primary opcodes
    typedef enum logic [5:0] {
        op_special = 6'h00,
        op_j       = 6'h02,
        op_jal     = 6'h03,
        op_beq     = 6'h04,
        op_bne     = 6'h05,
        op_addiu   = 6'h09,
        op_slti    = 6'h0a,
        op_andi    = 6'h0c,
        op_ori     = 6'h0d,
        op_xori    = 6'h0e,
        op_lui     = 6'h0f,
        op_lw      = 6'h23,
        op_sw      = 6'h2b
    } opcode_e;

    // special functs
    typedef enum logic [5:0] {
        fn_sll  = 6'h00,
        fn_srl  = 6'h02,
        fn_sra  = 6'h03,
        fn_jr   = 6'h08,
        fn_addu = 6'h21,
        fn_subu = 6'h23,
        fn_and  = 6'h24,
        fn_or   = 6'h25,
        fn_xor  = 6'h26,
        fn_nor  = 6'h27,
        fn_slt  = 6'h2a,
        fn_sltu = 6'h2b
    } funct_e;

endpackage
